/* common/chan_sel_macros.svh */
/*
 * channel down-selector sizing
 * stream widths, mask bank geometry and output FIFO depth
 */
`ifndef CHAN_SEL_MACROS_SVH
`define CHAN_SEL_MACROS_SVH

// sample stream
`define CS_DATA_W 32
`define CS_TUSER_W 24
`define CS_CHAN_W 11

// mask bank with 32 channels per word
`define CS_NUM_CHAN 256
`define CS_MASK_WORDS 8
`define CS_MASK_AW 3

// output FIFO
`define CS_FIFO_AW 5
`define CS_FIFO_AF 20

`endif

/* common/chan_sel_pkg.sv */
/*
 * channel down-selector types
 * user word seen either raw or split into frame info and channel
 */
`default_nettype none

`include "chan_sel_macros.svh"

package chan_sel_pkg;

    // channel number sits in the low bits of tuser
    typedef union packed {
        logic [`CS_TUSER_W-1:0] raw;
        struct packed {
            logic [`CS_TUSER_W-`CS_CHAN_W-1:0] frame_info;
            logic [`CS_CHAN_W-1:0] chan;
        } f;
    } tuser_u;

endpackage

`default_nettype wire

/* common/mask_wr_if.sv */
/*
 * mask write bus
 * word writes from the mask loader into the lookup bank,
 * plus the flag that a complete mask is in place
 */
`timescale 1ns/1ps
`default_nettype none

`include "chan_sel_macros.svh"

interface mask_wr_if;

    logic wr_en;
    logic [`CS_MASK_AW-1:0] wr_addr;
    logic [31:0] wr_data;
    logic load_done;

    modport loader (
        output wr_en,
        output wr_addr,
        output wr_data,
        output load_done
    );

    modport lookup (
        input wr_en,
        input wr_addr,
        input wr_data,
        input load_done
    );

endinterface

`default_nettype wire

/* sim.f */
+incdir+common
common/chan_sel_pkg.sv
common/mask_wr_if.sv
src/mask_loader.sv
src/mask_lookup.sv
src/sample_fifo.sv
src/chan_downselect.sv
verification/chan_downselect_sva.sv
verification/chan_downselect_checker.sv
verification/tb_chan_downselect.sv

/* src/chan_downselect.sv */
/*
 * channel down-selector top level
 * loads a channel mask from the select stream, then forwards
 * only the sample beats whose channel bit is set
 */
`timescale 1ns/1ps
`default_nettype none

`include "chan_sel_macros.svh"

module chan_downselect (
    input wire logic clk,
    input wire logic sync_reset,

    input wire logic select_valid,
    input wire logic [31:0] select_data,
    input wire logic select_last,
    output logic select_ready,

    input wire logic in_valid,
    input wire logic [`CS_DATA_W-1:0] in_data,
    input wire logic [`CS_TUSER_W-1:0] in_user,
    input wire logic in_last,
    input wire logic in_eob,
    output logic in_ready,

    output logic out_valid,
    output logic [`CS_DATA_W-1:0] out_data,
    output logic [`CS_TUSER_W-1:0] out_user,
    output logic out_last,
    output logic out_eob,
    input wire logic out_ready
);

    mask_wr_if wr_bus ();

    logic push;
    logic [`CS_DATA_W-1:0] push_data;
    logic [`CS_TUSER_W-1:0] push_user;
    logic push_last;
    logic push_eob;
    logic almost_full;

    mask_loader mask_loader_inst (
        .clk(clk),
        .sync_reset(sync_reset),
        .select_valid(select_valid),
        .select_data(select_data),
        .select_last(select_last),
        .select_ready(select_ready),
        .wr(wr_bus.loader)
    );

    mask_lookup mask_lookup_inst (
        .clk(clk),
        .sync_reset(sync_reset),
        .wr(wr_bus.lookup),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_user(in_user),
        .in_last(in_last),
        .in_eob(in_eob),
        .in_ready(in_ready),
        .almost_full(almost_full),
        .push(push),
        .push_data(push_data),
        .push_user(push_user),
        .push_last(push_last),
        .push_eob(push_eob)
    );

    sample_fifo sample_fifo_inst (
        .clk(clk),
        .sync_reset(sync_reset),
        .push(push),
        .push_data(push_data),
        .push_user(push_user),
        .push_last(push_last),
        .push_eob(push_eob),
        .almost_full(almost_full),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_user(out_user),
        .out_last(out_last),
        .out_eob(out_eob),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

/* src/mask_loader.sv */
/*
 * mask loader
 * accepts mask words on the select port, numbers them from zero
 * for each new mask and writes them one cycle later.
 * load_done is held while a complete mask is in place
 */
`timescale 1ns/1ps
`default_nettype none

`include "chan_sel_macros.svh"

module mask_loader (
    input wire logic clk,
    input wire logic sync_reset,

    input wire logic select_valid,
    input wire logic [31:0] select_data,
    input wire logic select_last,
    output logic select_ready,

    mask_wr_if.loader wr
);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] FILLING = 2'd1;
    localparam logic [1:0] LOADED = 2'd2;

    logic [1:0] state;
    logic [`CS_MASK_AW:0] word_cnt;
    logic select_take;
    logic new_mask;

    logic wr_en_q;
    logic [`CS_MASK_AW-1:0] wr_addr_q;
    logic [31:0] wr_data_q;

    assign select_take = select_valid & select_ready;
    // first word of a mask goes back to address 0
    assign new_mask = (state != FILLING);

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            state <= IDLE;
            select_ready <= 1'b0;
            word_cnt <= '0;
            wr_en_q <= 1'b0;
        end else begin
            select_ready <= 1'b1;
            wr_en_q <= 1'b0;
            if (select_take) begin
                if (new_mask) begin
                    word_cnt <= 1;
                    wr_en_q <= 1'b1;
                end else if (word_cnt < `CS_MASK_WORDS) begin
                    word_cnt <= word_cnt + 1'b1;
                    wr_en_q <= 1'b1;
                end
                // words past the bank end are simply not written
                state <= select_last ? LOADED : FILLING;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (select_take) begin
            wr_addr_q <= new_mask ? '0 : word_cnt[`CS_MASK_AW-1:0];
            wr_data_q <= select_data;
        end
    end

    assign wr.wr_en = wr_en_q;
    assign wr.wr_addr = wr_addr_q;
    assign wr.wr_data = wr_data_q;
    assign wr.load_done = (state == LOADED);

endmodule

`default_nettype wire

/* src/mask_lookup.sv */
/*
 * mask lookup
 * holds the mask bank and runs each accepted beat through a
 * two-stage pipeline: fetch its mask word, then pick the channel
 * bit and push kept beats into the output FIFO
 */
`timescale 1ns/1ps
`default_nettype none

`include "chan_sel_macros.svh"

module mask_lookup (
    input wire logic clk,
    input wire logic sync_reset,

    mask_wr_if.lookup wr,

    input wire logic in_valid,
    input wire logic [`CS_DATA_W-1:0] in_data,
    input chan_sel_pkg::tuser_u in_user,
    input wire logic in_last,
    input wire logic in_eob,
    output logic in_ready,

    input wire logic almost_full,

    output logic push,
    output logic [`CS_DATA_W-1:0] push_data,
    output chan_sel_pkg::tuser_u push_user,
    output logic push_last,
    output logic push_eob
);

    import chan_sel_pkg::*;

    localparam int BIT_IDX_W = 5;

    logic [31:0] mask_mem [0:`CS_MASK_WORDS-1];
    logic take;
    logic [`CS_MASK_AW-1:0] word_addr;
    logic [31:0] word_fetch;

    logic s1_valid;
    logic s1_oor;
    logic [31:0] s1_word;
    logic [BIT_IDX_W-1:0] s1_bit;
    logic [`CS_DATA_W-1:0] s1_data;
    tuser_u s1_user;
    logic s1_last;
    logic s1_eob;

    assign in_ready = wr.load_done & ~almost_full;
    assign take = in_valid & in_ready;
    assign word_addr = in_user.f.chan[BIT_IDX_W+`CS_MASK_AW-1:BIT_IDX_W];

    // a word written this cycle is forwarded to the fetch
    assign word_fetch = (wr.wr_en && wr.wr_addr == word_addr) ? wr.wr_data
                                                              : mask_mem[word_addr];

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            for (int i = 0; i < `CS_MASK_WORDS; i++) begin
                mask_mem[i] <= '0;
            end
        end else if (wr.wr_en) begin
            mask_mem[wr.wr_addr] <= wr.wr_data;
        end
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            s1_valid <= 1'b0;
            push <= 1'b0;
        end else begin
            s1_valid <= take;
            push <= s1_valid & ~s1_oor & s1_word[s1_bit];
        end
    end

    always_ff @(posedge clk) begin
        s1_word <= word_fetch;
        s1_oor <= (in_user.f.chan >= `CS_NUM_CHAN);
        s1_bit <= in_user.f.chan[BIT_IDX_W-1:0];
        s1_data <= in_data;
        s1_user <= in_user;
        s1_last <= in_last;
        s1_eob <= in_eob;

        push_data <= s1_data;
        push_user <= s1_user;
        push_last <= s1_last;
        push_eob <= s1_eob;
    end

endmodule

`default_nettype wire

/* src/sample_fifo.sv */
/*
 * output sample FIFO
 * stores kept beats and presents them through a registered
 * output stage. almost_full throttles the input early enough
 * to absorb the beats still in the lookup pipeline
 */
`timescale 1ns/1ps
`default_nettype none

`include "chan_sel_macros.svh"

module sample_fifo (
    input wire logic clk,
    input wire logic sync_reset,

    input wire logic push,
    input wire logic [`CS_DATA_W-1:0] push_data,
    input chan_sel_pkg::tuser_u push_user,
    input wire logic push_last,
    input wire logic push_eob,

    output logic almost_full,

    output logic out_valid,
    output logic [`CS_DATA_W-1:0] out_data,
    output chan_sel_pkg::tuser_u out_user,
    output logic out_last,
    output logic out_eob,
    input wire logic out_ready
);

    import chan_sel_pkg::*;

    localparam int DEPTH = 2 ** `CS_FIFO_AW;

    logic [`CS_DATA_W-1:0] mem_data [0:DEPTH-1];
    tuser_u mem_user [0:DEPTH-1];
    logic mem_last [0:DEPTH-1];
    logic mem_eob [0:DEPTH-1];

    logic [`CS_FIFO_AW-1:0] wr_ptr;
    logic [`CS_FIFO_AW-1:0] rd_ptr;
    logic [`CS_FIFO_AW:0] count;
    logic rd_en;

    // refill the output stage when it is empty or being taken
    assign rd_en = (count != 0) && (!out_valid || out_ready);
    assign almost_full = (count >= `CS_FIFO_AF);

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            if (rd_en) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= push_data;
            mem_user[wr_ptr] <= push_user;
            mem_last[wr_ptr] <= push_last;
            mem_eob[wr_ptr] <= push_eob;
        end
    end

    // output stage
    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_data <= mem_data[rd_ptr];
            out_user <= mem_user[rd_ptr];
            out_last <= mem_last[rd_ptr];
            out_eob <= mem_eob[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* verification/chan_downselect_checker.sv */
/*
 * channel down-selector checker
 * keeps a reference copy of the mask built from the select words,
 * predicts which input beats are kept and compares the output port
 */
`timescale 1ns/1ps
`default_nettype none

`include "chan_sel_macros.svh"

module chan_downselect_checker (
    input wire logic clk,
    input wire logic sync_reset,
    input wire logic select_valid,
    input wire logic [31:0] select_data,
    input wire logic select_last,
    input wire logic select_ready,
    input wire logic in_valid,
    input wire logic [`CS_DATA_W-1:0] in_data,
    input wire logic [`CS_TUSER_W-1:0] in_user,
    input wire logic in_last,
    input wire logic in_eob,
    input wire logic in_ready,
    input wire logic out_valid,
    input wire logic [`CS_DATA_W-1:0] out_data,
    input wire logic [`CS_TUSER_W-1:0] out_user,
    input wire logic out_last,
    input wire logic out_eob,
    input wire logic out_ready,
    output int mismatch_count,
    output int other_count,
    output int pending_count
);

    localparam int BEAT_W = `CS_DATA_W + `CS_TUSER_W + 2;

    logic [`CS_NUM_CHAN-1:0] ref_mask;
    logic ref_loaded;
    logic ref_new_mask;
    int ref_next_idx;
    logic [BEAT_W-1:0] expected_q [$];

    // one select word applied to the reference mask
    function automatic logic [`CS_NUM_CHAN-1:0] mask_after_word(
        input logic [`CS_NUM_CHAN-1:0] mask,
        input int idx,
        input logic [31:0] word
    );
        logic [`CS_NUM_CHAN-1:0] m;
        m = mask;
        if (idx < `CS_MASK_WORDS) begin
            m[idx*32 +: 32] = word;
        end
        return m;
    endfunction

    function automatic logic beat_kept(
        input logic [`CS_NUM_CHAN-1:0] mask,
        input logic [`CS_TUSER_W-1:0] user
    );
        int chan;
        chan = user[`CS_CHAN_W-1:0];
        if (chan >= `CS_NUM_CHAN) begin
            return 1'b0;
        end
        return mask[chan];
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    initial begin
        mismatch_count = 0;
        other_count = 0;
        pending_count = 0;
    end

    // sampled mid-cycle, where inputs and outputs are both settled
    always @(negedge clk) begin
        logic [BEAT_W-1:0] exp_beat;
        int idx;
        if (sync_reset) begin
            ref_mask = '0;
            ref_loaded = 1'b0;
            ref_new_mask = 1'b1;
            ref_next_idx = 0;
            expected_q.delete();
            if (out_valid) begin
                other_count++;
                $display("out_valid is high at %0t while reset is asserted", $time);
            end
        end else begin
            if (in_ready && !ref_loaded) begin
                other_count++;
                $display("in_ready is high at %0t before a complete mask is loaded", $time);
            end
            if (in_valid && in_ready && beat_kept(ref_mask, in_user)) begin
                expected_q.push_back({in_data, in_user, in_last, in_eob});
            end
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    other_count++;
                    $display("unexpected output beat at %0t", $time);
                end else begin
                    exp_beat = expected_q.pop_front();
                    check_field("data", out_data, exp_beat[BEAT_W-1 -: `CS_DATA_W]);
                    check_field("user", out_user, exp_beat[`CS_TUSER_W+1:2]);
                    check_field("last", out_last, exp_beat[1]);
                    check_field("eob", out_eob, exp_beat[0]);
                end
            end
            // mask words take effect for beats after this one
            if (select_valid && select_ready) begin
                idx = ref_new_mask ? 0 : ref_next_idx;
                ref_mask = mask_after_word(ref_mask, idx, select_data);
                ref_next_idx = idx + 1;
                ref_new_mask = select_last;
                ref_loaded = select_last;
            end
        end
        pending_count = expected_q.size();
    end

endmodule

`default_nettype wire

/* verification/chan_downselect_sva.sv */
/*
 * channel down-selector assertions
 * output hold under back-pressure, input gating on a loaded mask
 * and no select transfer during reset
 */
`timescale 1ns/1ps
`default_nettype none

`include "chan_sel_macros.svh"

module chan_downselect_sva (
    input wire logic clk,
    input wire logic sync_reset,
    input wire logic select_valid,
    input wire logic select_ready,
    input wire logic select_last,
    input wire logic in_ready,
    input wire logic load_done,
    input wire logic out_valid,
    input wire logic [`CS_DATA_W-1:0] out_data,
    input wire logic [`CS_TUSER_W-1:0] out_user,
    input wire logic out_last,
    input wire logic out_eob,
    input wire logic out_ready
);

    int fail_count = 0;

    out_held: assert property (@(posedge clk) disable iff (sync_reset)
        out_valid && !out_ready |=>
            out_valid && $stable({out_data, out_user, out_last, out_eob}))
    else begin
        fail_count++;
        $error("output beat dropped or changed before out_ready");
    end

    // a word that is not the last one starts or continues an incomplete mask
    ready_needs_mask: assert property (@(posedge clk) disable iff (sync_reset)
        select_valid && select_ready && !select_last |=> !load_done && !in_ready)
    else begin
        fail_count++;
        $error("in_ready or load_done high while a mask is incomplete");
    end

    no_select_in_reset: assert property (@(posedge clk)
        sync_reset |-> !(select_valid && select_ready))
    else begin
        fail_count++;
        $error("select word accepted during reset");
    end

endmodule

bind chan_downselect chan_downselect_sva sva_inst (
    .clk(clk),
    .sync_reset(sync_reset),
    .select_valid(select_valid),
    .select_ready(select_ready),
    .select_last(select_last),
    .in_ready(in_ready),
    .load_done(wr_bus.load_done),
    .out_valid(out_valid),
    .out_data(out_data),
    .out_user(out_user),
    .out_last(out_last),
    .out_eob(out_eob),
    .out_ready(out_ready)
);

`default_nettype wire

/* verification/tb_chan_downselect.sv */
/*
 * channel down-selector testbench
 * loads masks, streams random beats with random output stalls,
 * resets in mid-stream and reports the checker's error counts
 */
`timescale 1ns/1ps
`default_nettype none

`include "chan_sel_macros.svh"

module tb_chan_downselect;

    localparam int TOTAL_BEATS = 1130;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 2000;

    logic clk;
    logic sync_reset;
    logic select_valid;
    logic [31:0] select_data;
    logic select_last;
    logic select_ready;
    logic in_valid;
    logic [`CS_DATA_W-1:0] in_data;
    logic [`CS_TUSER_W-1:0] in_user;
    logic in_last;
    logic in_eob;
    logic in_ready;
    logic out_valid;
    logic [`CS_DATA_W-1:0] out_data;
    logic [`CS_TUSER_W-1:0] out_user;
    logic out_last;
    logic out_eob;
    logic out_ready;

    int mismatch_count;
    int other_count;
    int pending_count;
    int assert_count;
    integer seed;
    integer ready_seed;
    logic stall_mode;
    int ready_hold;
    logic [31:0] mask_words [0:8];

    chan_downselect chan_downselect_inst (.*);

    chan_downselect_checker checker_inst (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // output back-pressure with long low stretches in stall mode
    always @(posedge clk) begin
        #1;
        if (ready_hold == 0) begin
            if (stall_mode) begin
                out_ready = !out_ready;
                ready_hold = out_ready ? $unsigned($random(ready_seed)) % 4
                                       : $unsigned($random(ready_seed)) % 60;
            end else begin
                out_ready = ($random(ready_seed) & 1) != 0;
            end
        end else begin
            ready_hold--;
        end
    end

    task automatic load_mask(input int n_words);
        for (int i = 0; i < n_words; i++) begin
            select_valid = 1'b1;
            select_data = mask_words[i];
            select_last = (i == n_words - 1);
            @(negedge clk);
            while (!select_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        select_valid = 1'b0;
        select_last = 1'b0;
    endtask

    task automatic send_beats(input int n_beats, input int chan_range);
        for (int i = 0; i < n_beats; i++) begin
            repeat ($unsigned($random(seed)) % 3) begin
                @(posedge clk);
                #1;
            end
            in_valid = 1'b1;
            in_data = $random(seed);
            in_user = $random(seed);
            in_user[`CS_CHAN_W-1:0] = $unsigned($random(seed)) % chan_range;
            in_last = ($random(seed) % 8) == 0;
            in_eob = ($random(seed) % 32) == 0;
            // beat held until accepted
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain;
        int cycles;
        cycles = 0;
        while (pending_count != 0 && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        repeat (8) @(posedge clk);
        #1;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: test did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed = 32'h775f1cdc;
        ready_seed = $random(seed);
        stall_mode = 1'b0;
        ready_hold = 0;
        out_ready = 1'b0;
        // select word offered during reset must be ignored
        select_valid = 1'b1;
        select_data = $random(seed);
        select_last = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        in_user = '0;
        in_last = 1'b0;
        in_eob = 1'b0;
        sync_reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        sync_reset = 1'b0;
        select_valid = 1'b0;
        select_last = 1'b0;

        // beats offered before any mask must not be taken
        in_valid = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        in_valid = 1'b0;

        for (int i = 0; i < 8; i++) begin
            mask_words[i] = $random(seed);
        end
        load_mask(8);
        send_beats(300, 300);
        wait_drain();

        // all-ones mask with a cleared ninth word past the bank end
        for (int i = 0; i < 8; i++) begin
            mask_words[i] = '1;
        end
        mask_words[8] = '0;
        load_mask(9);
        send_beats(200, 512);
        wait_drain();

        // partial reload where words 3 to 7 stay all ones
        for (int i = 0; i < 3; i++) begin
            mask_words[i] = $random(seed);
        end
        load_mask(3);
        send_beats(200, 256);
        wait_drain();

        stall_mode = 1'b1;
        send_beats(300, 256);
        wait_drain();

        // reset while beats sit in the FIFO
        send_beats(30, 256);
        in_valid = 1'b1;
        select_valid = 1'b1;
        select_data = $random(seed);
        select_last = 1'b1;
        sync_reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        sync_reset = 1'b0;
        select_valid = 1'b0;
        select_last = 1'b0;
        stall_mode = 1'b0;
        repeat (20) @(posedge clk);
        #1;
        in_valid = 1'b0;

        // only words 0 and 1 nonzero after the reset
        for (int i = 0; i < 2; i++) begin
            mask_words[i] = $random(seed);
        end
        load_mask(2);
        send_beats(100, 256);
        wait_drain();

        assert_count = chan_downselect_inst.sva_inst.fail_count;
        if (pending_count != 0) begin
            $display("%0d expected beats never came out", pending_count);
        end
        $display("errors: %0d mismatches, %0d other, %0d leftover, %0d assertion",
                 mismatch_count, other_count, pending_count, assert_count);
        if (mismatch_count == 0 && other_count == 0 && pending_count == 0
                && assert_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
